// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = game_display_tb
FILELIST  = game_display_top.f
BIN       = obj_dir/V$(TOP)
LOG       = sim.log
SRCS      = $(wildcard src/*.sv bench/*.sv include/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/game_display_stim.txt ====
# color_a color_b score_a score_b winner leds slot0_pattern slot7_pattern
# all hex; colors 0 off 1 red 2 green 3 blue, winner 0 none 1 p1 2 p2
1 2 1 2 1 22 30 6D
3 0 3 4 2 08 79 33
0 1 5 1 0 04 5B 30
2 3 0 5 1 11 00 5B
1 1 6 3 2 24 00 79
0 0 7 0 0 00 00 00
3 3 2 2 1 09 6D 6D
2 2 4 5 2 12 33 5B
1 3 5 4 0 21 5B 33
3 2 3 1 1 0A 79 30

// ==== bench/game_display_sva.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "board_consts.svh"

module game_display_sva (
    input wire logic                   clk,
    input wire logic                   rst,
    input wire logic [`SCAN_SLOTS-1:0] seg_pos,
    input wire board_pkg::led_pair_t   leds,
    input wire board_pkg::lcd_bus_t    lcd
);

    scan_onehot: assert property (@(posedge clk) disable iff (!rst)
        (seg_pos != '0) |-> $onehot(seg_pos))
        else $error("seg_pos is not one-hot");

    // Each slot hands over to the next one up
    scan_rotate: assert property (@(posedge clk) disable iff (!rst)
        ($past(seg_pos) != '0) |->
        (seg_pos == {$past(seg_pos[`SCAN_SLOTS-2:0]), $past(seg_pos[`SCAN_SLOTS-1])}))
        else $error("seg_pos did not rotate left");

    lamp_single: assert property (@(posedge clk) disable iff (!rst)
        $onehot0(leds.lamp_a) && $onehot0(leds.lamp_b))
        else $error("more than one lamp bit lit");

    lcd_write_only: assert property (@(posedge clk) disable iff (!rst)
        lcd.e |-> !lcd.rw)
        else $error("lcd rw high during strobe");

endmodule

bind game_display_top game_display_sva i_sva (
    .clk     (clk),
    .rst     (rst),
    .seg_pos (seg_pos),
    .leds    (leds),
    .lcd     (lcd)
);

`default_nettype wire

// ==== bench/game_display_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "board_consts.svh"

module game_display_tb;

    typedef struct packed {
        logic [1:0] color_a;
        logic [1:0] color_b;
        logic [2:0] score_a;
        logic [2:0] score_b;
        logic [1:0] winner;
        logic [5:0] leds;
        logic [6:0] pat_a;
        logic [6:0] pat_b;
    } vec_t;

    localparam int hold_cycles = 40;
    localparam int lcd_init = (`LCD_T_POWERUP + 1) + 3 * (`LCD_T_CMD + 1);
    localparam int lcd_loop = 2 * (`LCD_T_LINE + 1) + (`LCD_T_HOME + 1) + (`LCD_T_CLEAR + 1);
    localparam logic [6:0] seg_table [8] = '{`SEG_BLANK, `SEG_DIGIT_1, `SEG_DIGIT_2,
        `SEG_DIGIT_3, `SEG_DIGIT_4, `SEG_DIGIT_5, `SEG_BLANK, `SEG_BLANK};

    logic                   clk;
    logic                   rst;
    board_pkg::color_code_e color_a;
    board_pkg::color_code_e color_b;
    logic [`SCORE_W-1:0]    score_a;
    logic [`SCORE_W-1:0]    score_b;
    board_pkg::winner_e     winner;
    board_pkg::led_pair_t   leds;
    logic [`SEG_W-1:0]      seg;
    logic [`SCAN_SLOTS-1:0] seg_pos;
    board_pkg::lcd_bus_t    lcd;

    board_pkg::winner_e win_prev; // Input as sampled at the last edge
    board_pkg::winner_e msg_win;
    vec_t vecs[$];
    int   errors = 0;
    int   cycles = 0;
    int   limit = 0;
    int   msgs_done [4] = '{0, 0, 0, 0};
    int   lcd_line = 0;
    int   char_idx = 0;
    logic seen_first = 1'b0;

    tb_clock_gen u_clock (
        .clk (clk),
        .rst (rst)
    );

    game_display_top i_game_display_top (
        .clk     (clk),
        .rst     (rst),
        .color_a (color_a),
        .color_b (color_b),
        .score_a (score_a),
        .score_b (score_b),
        .winner  (winner),
        .leds    (leds),
        .seg     (seg),
        .seg_pos (seg_pos),
        .lcd     (lcd)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("** Error %s: got 0x%0h, expected 0x%0h at %0t", name, got, expected,
                     $time);
        end
    endtask

    // Red, green, blue light r, g, b in that order
    function automatic logic [2:0] lamp_rule(input logic [1:0] code);
        return (code == 2'd0) ? 3'b000 : (3'b100 >> (code - 2'd1));
    endfunction

    function automatic logic [7:0] text_rule(input board_pkg::winner_e w, input logic line2,
                                             input logic [3:0] pos);
        logic [7:0] top [9];
        logic [7:0] bottom [9];
        top = '{`CHR_SPACE, `CHR_P, `CHR_1, `CHR_SPACE, `CHR_W, `CHR_I, `CHR_N,
                `CHR_SPACE, `CHR_SPACE};
        bottom = '{`CHR_SPACE, `CHR_HEART, `CHR_HEART, `CHR_HEART, `CHR_SPACE,
                   `CHR_HEART, `CHR_HEART, `CHR_HEART, `CHR_SPACE};
        if (w == board_pkg::win_p2) begin
            top[2] = `CHR_2;
        end
        if (w != board_pkg::win_p1 && w != board_pkg::win_p2) begin
            return `CHR_SPACE; // Blank screen
        end
        return line2 ? bottom[pos] : top[pos];
    endfunction

    always @(posedge clk) begin
        win_prev <= winner;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout: run passed the limit of %0d cycles, %0d errors", limit, errors);
            $display("Test failures found");
            $finish;
        end
    end

    // LCD byte monitor
    always @(negedge clk) begin
        if (rst && lcd.e) begin
            check_value("lcd.rw", 32'(lcd.rw), 0);
            if (!seen_first) begin
                seen_first = 1'b1;
                check_value("first lcd byte", 32'(lcd.data), 32'(`LCD_CMD_FUNCTION));
            end
            if (!lcd.rs) begin
                if (lcd_line != 0) begin
                    check_value($sformatf("lcd line%0d length", lcd_line), 32'(char_idx),
                                32'(`LCD_LINE_CHARS));
                end
                if (lcd_line == 2) begin
                    msgs_done[msg_win]++;
                end
                if (lcd.data == `LCD_CMD_LINE1) begin
                    lcd_line = 1;
                    msg_win = win_prev; // Same sample the banner latches
                end else if (lcd.data == `LCD_CMD_LINE2 && lcd_line == 1) begin
                    lcd_line = 2;
                end else begin
                    lcd_line = 0;
                end
                char_idx = 0;
            end else if (lcd_line != 0) begin
                if (char_idx < `LCD_LINE_CHARS) begin
                    check_value($sformatf("lcd line%0d char %0d", lcd_line, char_idx),
                                32'(lcd.data), 32'(text_rule(msg_win, lcd_line == 2,
                                                             4'(char_idx))));
                end
                char_idx++;
            end
        end
    end

    initial begin : main
        int fd;
        int n;
        int start;
        string text;
        logic [31:0] f [8];
        vec_t v;
        board_pkg::winner_e lcd_order [3];
        logic [`SCAN_SLOTS-1:0] exp_pos;

        color_a = board_pkg::color_off;
        color_b = board_pkg::color_off;
        score_a = '0;
        score_b = '0;
        winner = board_pkg::win_none;
        lcd_order = '{board_pkg::win_p1, board_pkg::win_p2, board_pkg::win_none};

        fd = $fopen("bench/game_display_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file bench/game_display_stim.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                text = "";
                n = $fgets(text, fd);
                if (n > 0 && text.substr(0, 0) != "#") begin
                    n = $sscanf(text, "%h %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                    if (n == 8) begin
                        v = '{f[0][1:0], f[1][1:0], f[2][2:0], f[3][2:0], f[4][1:0],
                              f[5][5:0], f[6][6:0], f[7][6:0]};
                        vecs.push_back(v);
                    end
                end
            end
            $fclose(fd);
        end
        if (vecs.size() == 0) begin
            $display("No stimulus vectors were read");
            errors++;
        end
        // Vector holds, then up to three LCD loops for the text phases
        limit = vecs.size() * hold_cycles + 3 * (lcd_init + lcd_loop) + 100;

        @(posedge clk);
        while (!rst) begin
            @(negedge clk);
            check_value("leds in reset", 32'(leds), 0);
            check_value("lcd.e in reset", 32'(lcd.e), 0);
            check_value("seg_pos in reset", 32'(seg_pos), 0);
        end
        @(posedge clk);
        @(negedge clk);
        check_value("leds after reset", 32'(leds), 0);
        check_value("lcd.e after reset", 32'(lcd.e), 0);
        exp_pos = 8'h01; // Slot 0 on the first clock out of reset
        check_value("seg_pos after reset", 32'(seg_pos), 32'(exp_pos));

        foreach (vecs[i]) begin
            v = vecs[i];
            check_value("stim leds", 32'(v.leds),
                        32'({lamp_rule(v.color_a), lamp_rule(v.color_b)}));
            check_value("stim slot 0", 32'(v.pat_a), 32'(seg_table[v.score_a]));
            check_value("stim slot 7", 32'(v.pat_b), 32'(seg_table[v.score_b]));
            @(posedge clk);
            #1;
            color_a = board_pkg::color_code_e'(v.color_a);
            color_b = board_pkg::color_code_e'(v.color_b);
            score_a = v.score_a;
            score_b = v.score_b;
            winner = board_pkg::winner_e'(v.winner);
            for (int c = 1; c <= hold_cycles; c++) begin
                @(negedge clk);
                exp_pos = {exp_pos[`SCAN_SLOTS-2:0], exp_pos[`SCAN_SLOTS-1]}; // Next slot
                check_value("seg_pos", 32'(seg_pos), 32'(exp_pos));
                if (c == 2) begin
                    check_value("leds", 32'(leds), 32'(v.leds));
                end
                if (c > hold_cycles - 16) begin
                    if (exp_pos == 8'h01) begin
                        check_value("seg slot 0", 32'(seg), 32'(v.pat_a));
                    end else if (exp_pos == 8'h80) begin
                        check_value("seg slot 7", 32'(seg), 32'(v.pat_b));
                    end else begin
                        check_value("seg blank slot", 32'(seg), 32'(`SEG_BLANK));
                    end
                end
            end
        end

        // Hold each winner until one full message for it is checked
        foreach (lcd_order[k]) begin
            @(posedge clk);
            #1;
            winner = lcd_order[k];
            start = msgs_done[lcd_order[k]];
            while (msgs_done[lcd_order[k]] == start) begin
                @(negedge clk);
            end
        end

        $display("Run complete: %0d errors over %0d vectors and %0d LCD messages", errors,
                 vecs.size(), msgs_done[0] + msgs_done[1] + msgs_done[2]);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    initial begin
        rst = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst = 1'b1; // Released off the edge
    end

endmodule

`default_nettype wire

// ==== game_display_top.f ====
+incdir+include
src/board_pkg.sv
src/rgb_led_decoder.sv
src/digit_encoder.sv
src/segment_scanner.sv
src/lcd_banner.sv
src/game_display_top.sv
bench/tb_clock_gen.sv
bench/game_display_sva.sv
bench/game_display_tb.sv

// ==== include/board_consts.svh ====
`ifndef BOARD_CONSTS_SVH
`define BOARD_CONSTS_SVH

// Board widths
`define SEG_W       7
`define SCAN_SLOTS  8
`define SCORE_W     3
`define LCD_DATA_W  8

// Segment patterns, bit 6 is segment a
`define SEG_BLANK   7'b0000000
`define SEG_DIGIT_1 7'b0110000
`define SEG_DIGIT_2 7'b1101101
`define SEG_DIGIT_3 7'b1111001
`define SEG_DIGIT_4 7'b0110011
`define SEG_DIGIT_5 7'b1011011

// LCD instruction bytes
`define LCD_CMD_FUNCTION 8'h3C
`define LCD_CMD_ENTRY    8'h06
`define LCD_CMD_DISPLAY  8'h0C
`define LCD_CMD_LINE1    8'h80
`define LCD_CMD_LINE2    8'hC0
`define LCD_CMD_HOME     8'h02
`define LCD_CMD_CLEAR    8'h01

// Glyph codes
`define CHR_SPACE 8'h20
`define CHR_P     8'h50
`define CHR_1     8'h31
`define CHR_2     8'h32
`define CHR_W     8'h57
`define CHR_I     8'h69
`define CHR_N     8'h6E
`define CHR_HEART 8'h9D

// Dwell per state, in cycles minus one
`define LCD_T_POWERUP  70
`define LCD_T_CMD      30
`define LCD_T_LINE     20
`define LCD_T_HOME     400
`define LCD_T_CLEAR    200
`define LCD_LINE_CHARS 9

`endif

// ==== src/board_pkg.sv ====
`default_nettype none
`include "board_consts.svh"

package board_pkg;

    typedef enum logic [1:0] {
        color_off,
        color_red,
        color_green,
        color_blue
    } color_code_e;

    typedef enum logic [1:0] {
        win_none,
        win_p1,
        win_p2
    } winner_e;

    typedef enum logic [2:0] {
        st_powerup,
        st_function,
        st_entry,
        st_display,
        st_line1,
        st_line2,
        st_home,
        st_clear
    } lcd_state_e;

    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } rgb_t;

    typedef struct packed {
        rgb_t lamp_a;
        rgb_t lamp_b;
    } led_pair_t;

    typedef struct packed {
        logic                   e;
        logic                   rs;
        logic                   rw;
        logic [`LCD_DATA_W-1:0] data;
    } lcd_bus_t;

endpackage

`default_nettype wire

// ==== src/digit_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "board_consts.svh"

module digit_encoder (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic [`SCORE_W-1:0] score,
    output logic [`SEG_W-1:0]       pattern
);

    logic [`SEG_W-1:0] decoded; // First stage

    always_ff @(posedge clk) begin
        if (!rst) begin
            decoded <= `SEG_BLANK;
            pattern <= `SEG_BLANK;
        end else begin
            case (score)
                3'd1:    decoded <= `SEG_DIGIT_1;
                3'd2:    decoded <= `SEG_DIGIT_2;
                3'd3:    decoded <= `SEG_DIGIT_3;
                3'd4:    decoded <= `SEG_DIGIT_4;
                3'd5:    decoded <= `SEG_DIGIT_5;
                default: decoded <= `SEG_BLANK; // 0, 6 and 7 not shown
            endcase
            pattern <= decoded;
        end
    end

endmodule

`default_nettype wire

// ==== src/game_display_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "board_consts.svh"

module game_display_top (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire board_pkg::color_code_e color_a,
    input  wire board_pkg::color_code_e color_b,
    input  wire logic [`SCORE_W-1:0]    score_a,
    input  wire logic [`SCORE_W-1:0]    score_b,
    input  wire board_pkg::winner_e     winner,
    output board_pkg::led_pair_t        leds,
    output logic [`SEG_W-1:0]           seg,
    output logic [`SCAN_SLOTS-1:0]      seg_pos,
    output board_pkg::lcd_bus_t         lcd
);

    logic [`SEG_W-1:0] pattern_a;
    logic [`SEG_W-1:0] pattern_b;

    rgb_led_decoder u_leds (
        .clk     (clk),
        .rst     (rst),
        .color_a (color_a),
        .color_b (color_b),
        .leds    (leds)
    );

    digit_encoder u_digit_a (
        .clk     (clk),
        .rst     (rst),
        .score   (score_a),
        .pattern (pattern_a)
    );

    digit_encoder u_digit_b (
        .clk     (clk),
        .rst     (rst),
        .score   (score_b),
        .pattern (pattern_b)
    );

    segment_scanner u_scanner (
        .clk       (clk),
        .rst       (rst),
        .pattern_a (pattern_a),
        .pattern_b (pattern_b),
        .seg       (seg),
        .seg_pos   (seg_pos)
    );

    lcd_banner u_lcd (
        .clk    (clk),
        .rst    (rst),
        .winner (winner),
        .lcd    (lcd)
    );

endmodule

`default_nettype wire

// ==== src/lcd_banner.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "board_consts.svh"

module lcd_banner (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire board_pkg::winner_e winner,
    output board_pkg::lcd_bus_t     lcd
);

    localparam int cnt_w = $clog2(`LCD_T_HOME + 1);

    board_pkg::lcd_state_e state;
    board_pkg::winner_e    win_q;    // Message for the current refresh
    board_pkg::lcd_bus_t   lcd_next;
    logic [cnt_w-1:0]      count;
    logic [cnt_w-1:0]      dwell;
    logic                  last;

    // Glyph at position 1..9 of a line
    function automatic logic [`LCD_DATA_W-1:0] banner_char(
        input board_pkg::winner_e w,
        input logic               line2,
        input logic [3:0]         pos
    );
        logic [`LCD_DATA_W-1:0] c;
        c = `CHR_SPACE;
        if (w == board_pkg::win_p1 || w == board_pkg::win_p2) begin
            if (line2) begin
                case (pos)
                    4'd2, 4'd3, 4'd4, 4'd6, 4'd7, 4'd8: c = `CHR_HEART;
                    default:                            c = `CHR_SPACE;
                endcase
            end else begin
                case (pos)
                    4'd2:    c = `CHR_P;
                    4'd3:    c = (w == board_pkg::win_p1) ? `CHR_1 : `CHR_2;
                    4'd5:    c = `CHR_W;
                    4'd6:    c = `CHR_I;
                    4'd7:    c = `CHR_N;
                    default: c = `CHR_SPACE;
                endcase
            end
        end
        return c;
    endfunction

    always_comb begin
        case (state)
            board_pkg::st_powerup:  dwell = cnt_w'(`LCD_T_POWERUP);
            board_pkg::st_function,
            board_pkg::st_entry,
            board_pkg::st_display:  dwell = cnt_w'(`LCD_T_CMD);
            board_pkg::st_line1,
            board_pkg::st_line2:    dwell = cnt_w'(`LCD_T_LINE);
            board_pkg::st_home:     dwell = cnt_w'(`LCD_T_HOME);
            default:                dwell = cnt_w'(`LCD_T_CLEAR);
        endcase
    end

    assign last = (count == dwell);

    always_comb begin
        // Command states strobe once on entry
        lcd_next = '{e: (count == '0), rs: 1'b0, rw: 1'b0, data: `LCD_CMD_CLEAR};
        case (state)
            board_pkg::st_powerup: lcd_next = '{e: 1'b0, rs: 1'b1, rw: 1'b1, data: '0};
            board_pkg::st_function: lcd_next.data = `LCD_CMD_FUNCTION;
            board_pkg::st_entry:    lcd_next.data = `LCD_CMD_ENTRY;
            board_pkg::st_display:  lcd_next.data = `LCD_CMD_DISPLAY;
            board_pkg::st_home:     lcd_next.data = `LCD_CMD_HOME;
            board_pkg::st_line1,
            board_pkg::st_line2: begin
                if (count == '0) begin
                    lcd_next.data = (state == board_pkg::st_line1) ? `LCD_CMD_LINE1
                                                                   : `LCD_CMD_LINE2;
                end else begin
                    lcd_next.rs = 1'b1;
                    lcd_next.e  = (count <= cnt_w'(`LCD_LINE_CHARS));
                    if (lcd_next.e) begin
                        lcd_next.data = banner_char(win_q, state == board_pkg::st_line2,
                                                    count[3:0]);
                    end else begin
                        lcd_next.data = `CHR_SPACE; // Idle tail of the line
                    end
                end
            end
            default: lcd_next.data = `LCD_CMD_CLEAR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= board_pkg::st_powerup;
            count <= '0;
            win_q <= board_pkg::win_none;
            lcd   <= '{e: 1'b0, rs: 1'b1, rw: 1'b1, data: '0};
        end else begin
            lcd   <= lcd_next;
            count <= last ? '0 : count + 1'b1;

            if (state == board_pkg::st_line1 && count == '0) begin
                win_q <= winner; // Both lines follow this sample
            end

            if (last) begin
                case (state)
                    board_pkg::st_powerup:  state <= board_pkg::st_function;
                    board_pkg::st_function: state <= board_pkg::st_entry;
                    board_pkg::st_entry:    state <= board_pkg::st_display;
                    board_pkg::st_display:  state <= board_pkg::st_line1;
                    board_pkg::st_line1:    state <= board_pkg::st_line2;
                    board_pkg::st_line2:    state <= board_pkg::st_home;
                    board_pkg::st_home:     state <= board_pkg::st_clear;
                    default:                state <= board_pkg::st_line1; // Refresh loop
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/rgb_led_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module rgb_led_decoder (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire board_pkg::color_code_e color_a,
    input  wire board_pkg::color_code_e color_b,
    output board_pkg::led_pair_t        leds
);

    function automatic board_pkg::rgb_t lamp_of(input board_pkg::color_code_e c);
        board_pkg::rgb_t l;
        l = '0;
        case (c)
            board_pkg::color_red:   l.r = 1'b1;
            board_pkg::color_green: l.g = 1'b1;
            board_pkg::color_blue:  l.b = 1'b1;
            default:                l = '0; // Off, lamp dark
        endcase
        return l;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst) begin
            leds <= '0;
        end else begin
            leds.lamp_a <= lamp_of(color_a);
            leds.lamp_b <= lamp_of(color_b);
        end
    end

endmodule

`default_nettype wire

// ==== src/segment_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "board_consts.svh"

module segment_scanner (
    input  wire logic [`SEG_W-1:0] pattern_a,
    input  wire logic [`SEG_W-1:0] pattern_b,
    input  wire logic              clk,
    input  wire logic              rst,
    output logic [`SEG_W-1:0]      seg,
    output logic [`SCAN_SLOTS-1:0] seg_pos
);

    localparam int slot_w = $clog2(`SCAN_SLOTS);

    logic [slot_w-1:0] slot;

    always_ff @(posedge clk) begin
        if (!rst) begin
            slot    <= '0;
            seg_pos <= '0;
            seg     <= `SEG_BLANK;
        end else begin
            slot          <= slot + 1'b1; // Wraps after last slot
            seg_pos       <= '0;
            seg_pos[slot] <= 1'b1;

            // Player A leftmost, player B rightmost
            if (slot == '0) begin
                seg <= pattern_a;
            end else if (slot == slot_w'(`SCAN_SLOTS - 1)) begin
                seg <= pattern_b;
            end else begin
                seg <= `SEG_BLANK;
            end
        end
    end

endmodule

`default_nettype wire
